//--- filelist.f
+incdir+common
common/sm83Pkg.sv
common/busPkg.sv
common/coreBus.sv
core/alu.sv
core/regFile.sv
core/irqLogic.sv
core/sequencer.sv
core/sm83Core.sv
bench/sm83Core_checker.sv
bench/sm83CoreTb.sv

//--- bench/sm83CoreTb.sv
`timescale 1ns/1ps
`include "sm83_consts.svh"

module sm83CoreTb;
	import sm83Pkg::*;

	localparam int TIMEOUT = 400;               // Cycles allowed for one wait
	localparam int FETCHES = 0;
	localparam int WRITES  = 1;
	localparam int ACKS    = 2;

	logic                       clk = 1'b0;
	logic                       rst;
	logic [15:0]                addr;
	logic [7:0]                 dataIn = 8'h00;
	logic [7:0]                 dataOut;
	logic                       rd;
	logic                       wr;
	logic                       m1;
	logic [`SM83_IRQ_LINES-1:0] irqTrig;
	logic [`SM83_IRQ_LINES-1:0] irqAck;

	logic [7:0]  mem [65536];                   // 64 KB memory model
	logic [15:0] pAddr;                         // Next program byte
	logic [15:0] fetchQ[$];                     // Address of every opcode fetch
	logic [15:0] wrAddrQ[$];
	logic [7:0]  wrDataQ[$];
	logic [4:0]  ackQ[$];
	int          readCount = 0;
	logic        rdQ;
	int          errors;
	int          checks;

	aluOpT      tOp[$];                         // ALU table, one entry per row
	logic [7:0] tP[$], tQ[$], tX[$], tY[$], tExp[$];

	sm83Core u_dut (
		.clk(clk), .rst(rst), .addr(addr), .dataIn(dataIn), .dataOut(dataOut),
		.rd(rd), .wr(wr), .m1(m1), .irqTrig(irqTrig), .irqAck(irqAck)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		#1;
		dataIn = rd ? mem[addr] : 8'h00;        // Memory answers while rd is high
	end

	// Bus monitor, logs fetches, writes and acks
	always @(posedge clk) begin
		if (rst) begin
			fetchQ.delete();
			wrAddrQ.delete();
			wrDataQ.delete();
			ackQ.delete();
			readCount = 0;
		end else begin
			if (rd && !rdQ) begin
				readCount++;
				if (m1)
					fetchQ.push_back(addr);
			end
			if (wr) begin
				wrAddrQ.push_back(addr);
				wrDataQ.push_back(dataOut);
			end
			if (irqAck != '0)
				ackQ.push_back(irqAck);
		end
		rdQ <= rd;
	end

	task automatic nextCycle();
		@(posedge clk);
		#1;                                     // Drive point
	endtask

	task automatic checkVal(input string name, input logic [15:0] exp, input logic [15:0] got);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("error %s exp %h got %h", name, exp, got);
		end
	endtask

	function automatic int logSize(input int kind);
		case (kind)
			FETCHES: return fetchQ.size();
			WRITES:  return wrAddrQ.size();
			default: return ackQ.size();
		endcase
	endfunction

	task automatic waitLog(input int kind, input int n, input string what);
		int k;
		for (k = 0; k < TIMEOUT && logSize(kind) < n; k++)
			nextCycle();
		if (logSize(kind) < n) begin
			errors++;
			$display("timed out waiting for %s", what);
		end
	endtask

	task automatic waitFetchAt(input logic [15:0] a, input string what);
		int k;
		for (k = 0; k < TIMEOUT; k++) begin
			if (fetchQ.size() > 0 && fetchQ[$] == a)
				break;
			nextCycle();
		end
		if (k == TIMEOUT) begin
			errors++;
			$display("timed out waiting for %s", what);
		end
	endtask

	task automatic resetDut();
		rst     = 1'b1;
		irqTrig = '0;
		repeat (8) begin
			nextCycle();
			checkVal("rd", 16'h0, 16'(rd));    // Bus quiet through reset
			checkVal("wr", 16'h0, 16'(wr));
			checkVal("m1", 16'h0, 16'(m1));
			checkVal("irqAck", 16'h0, 16'(irqAck));
		end
		rst = 1'b0;
	endtask

	task automatic clearMem();
		foreach (mem[i])
			mem[i] = 8'h00;                     // All NOP
		pAddr = `SM83_RESET_PC;
	endtask

	// Opcode plus an optional little-endian immediate
	task automatic emit(input logic [7:0] op, input int len = 1, input logic [15:0] imm = 16'h0);
		mem[pAddr] = op;
		if (len > 1)
			mem[pAddr + 16'd1] = imm[7:0];
		if (len > 2)
			mem[pAddr + 16'd2] = imm[15:8];
		pAddr = pAddr + 16'(len);
	endtask

	task automatic addRow(input aluOpT op, input logic [7:0] p, input logic [7:0] q,
		input logic [7:0] x, input logic [7:0] y, input logic [7:0] e);
		tOp.push_back(op);
		tP.push_back(p);
		tQ.push_back(q);
		tX.push_back(x);
		tY.push_back(y);
		tExp.push_back(e);
	endtask

	// Value left in A, CP leaves A untouched
	function automatic logic [7:0] expectAlu(input aluOpT op, input logic [7:0] a,
		input logic [7:0] b, input logic cin);
		case (op)
			ADD:     return a + b;
			ADC:     return a + b + {7'd0, cin};
			SUB:     return a - b;
			SBC:     return a - b - {7'd0, cin};
			AND:     return a & b;
			XOR:     return a ^ b;
			OR:      return a | b;
			default: return a;
		endcase
	endfunction

	task automatic runAluRow(input int i);
		logic [15:0] hlVal;
		hlVal = {8'hC0, 8'(i)};
		clearMem();
		if (tOp[i] inside {ADC, SBC}) begin
			emit(8'h3E, 2, 16'(tP[i]));
			emit(8'h06, 2, 16'(tQ[i]));
			emit(8'h80);                        // ADD B sets up the carry
		end
		emit(8'h3E, 2, 16'(tX[i]));             // LD A,x
		emit(8'h06, 2, 16'(tY[i]));             // LD B,y
		emit({2'b10, tOp[i], 3'b000});          // op B
		emit(8'h26, 2, 16'(hlVal[15:8]));
		emit(8'h2E, 2, 16'(hlVal[7:0]));
		emit(8'h77);                            // LD (HL),A
		resetDut();
		waitLog(WRITES, 1, "the LD (HL),A write");
		checkVal("addr", hlVal, wrAddrQ[0]);
		checkVal("dataOut", 16'(tExp[i]), 16'(wrDataQ[0]));
	endtask

	task automatic runJump();
		clearMem();
		emit(8'hC3, 3, 16'h1234);
		resetDut();
		waitLog(FETCHES, 2, "the fetch at the jump target");
		checkVal("addr", `SM83_RESET_PC, fetchQ[0]);   // First fetch after reset
		checkVal("addr", 16'h1234, fetchQ[1]);         // PC+3 is skipped
	endtask

	task automatic runIrq();
		logic [15:0] retPc;
		int          nFetch;
		clearMem();
		emit(8'h31, 3, 16'hD000);               // LD SP,D000
		emit(8'h3E, 2, 16'h001C);               // Enable lines 2 to 4
		emit(8'h26, 2, 16'h00FF);
		emit(8'h2E, 2, 16'h00FF);
		emit(8'h77);                            // Store lands in IE
		emit(8'hFB);                            // EI, then NOPs
		resetDut();
		waitFetchAt(16'h000D, "the NOPs after EI");
		checkVal("wr pulses", 16'h0, 16'(wrAddrQ.size()));
		irqTrig = 5'b11000;                     // Lines 3 and 4 both enabled, 3 wins
		waitLog(ACKS, 1, "irqAck");
		retPc  = fetchQ[$] + 16'd1;
		nFetch = fetchQ.size();
		checkVal("irqAck", 16'h0008, 16'(ackQ[0]));
		waitLog(WRITES, 2, "the two stack writes");
		checkVal("addr", 16'hCFFF, wrAddrQ[0]);
		checkVal("dataOut", 16'(retPc[15:8]), 16'(wrDataQ[0]));
		checkVal("addr", 16'hCFFE, wrAddrQ[1]);
		checkVal("dataOut", 16'(retPc[7:0]), 16'(wrDataQ[1]));
		waitLog(FETCHES, nFetch + 1, "the fetch at the vector");
		checkVal("addr", `SM83_IRQ_BASE + 16'd24, fetchQ[nFetch]);
		checkVal("irqAck pulses", 16'h1, 16'(ackQ.size()));   // Line 4 stays masked by IME
	endtask

	task automatic runHalt();
		int nRead;
		clearMem();
		emit(8'h3E, 2, 16'h0004);               // Enable line 2 only
		emit(8'h26, 2, 16'h00FF);
		emit(8'h2E, 2, 16'h00FF);
		emit(8'h77);
		emit(8'hFB);                            // EI so that DI has work to do
		emit(8'hF3);                            // DI
		emit(8'h76);                            // HALT at 0x0009
		resetDut();
		waitFetchAt(16'h0009, "the HALT fetch");
		nRead = readCount;
		repeat (40)
			nextCycle();
		checkVal("rd pulses in HALT", 16'(nRead), 16'(readCount));
		irqTrig = 5'b00100;
		waitFetchAt(16'h000A, "the fetch after HALT");
		checkVal("wr pulses", 16'h0, 16'(wrAddrQ.size()));
		checkVal("irqAck pulses", 16'h0, 16'(ackQ.size()));
	endtask

	initial begin
		aluOpT      op;
		logic [7:0] p, q, x, y;
		logic [8:0] sum;
		rst     = 1'b1;
		irqTrig = '0;
		errors  = 0;
		checks  = 0;
		void'($urandom(32'h15e0));
		//     op   setup pair    A      B      A after
		addRow(ADD, 8'h00, 8'h00, 8'h3A, 8'hC6, 8'h00);
		addRow(ADC, 8'hFF, 8'h01, 8'h12, 8'h34, 8'h47);
		addRow(ADC, 8'h10, 8'h20, 8'h12, 8'h34, 8'h46);
		addRow(SUB, 8'h00, 8'h00, 8'h50, 8'h20, 8'h30);
		addRow(SBC, 8'hF0, 8'h20, 8'h50, 8'h20, 8'h2F);
		addRow(SBC, 8'h10, 8'h01, 8'h05, 8'h07, 8'hFE);
		addRow(AND, 8'h00, 8'h00, 8'hF0, 8'h3C, 8'h30);
		addRow(XOR, 8'h00, 8'h00, 8'hF0, 8'h3C, 8'hCC);
		addRow(OR,  8'h00, 8'h00, 8'hF0, 8'h3C, 8'hFC);
		addRow(CP,  8'h00, 8'h00, 8'h42, 8'h42, 8'h42);
		for (int r = 0; r < 4; r++) begin
			op  = aluOpT'(3'($urandom()));
			p   = 8'($urandom());
			q   = 8'($urandom());
			x   = 8'($urandom());
			y   = 8'($urandom());
			sum = {1'b0, p} + {1'b0, q};        // Carry left by the setup ADD
			addRow(op, p, q, x, y, expectAlu(op, x, y, sum[8]));
		end
		runJump();
		for (int i = 0; i < tOp.size(); i++)
			runAluRow(i);
		runIrq();
		runHalt();
		$display("checks %0d errors %0d assertion failures %0d",
			checks, errors, u_dut.u_chk.violations);
		if (errors == 0 && u_dut.u_chk.violations == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- bench/sm83Core_checker.sv
`timescale 1ns/1ps
`include "sm83_consts.svh"

module sm83Core_checker (
	input logic                       clk,
	input logic                       rst,
	input logic [15:0]                addr,
	input logic                       rd,
	input logic                       wr,
	input logic                       m1,
	input logic [`SM83_IRQ_LINES-1:0] irqAck,
	input busPkg::slotT               slot       // Slot inside the current machine cycle
);
	import busPkg::*;

	int violations = 0;                          // Read by the testbench at the end

	rdWrExclusive: assert property (@(posedge clk) disable iff (rst) !(rd && wr))
		else begin
			violations++;
			$error("rd and wr are high together");
		end

	// Opcode fetch strobes rd in the middle two slots
	fetchReads: assert property (@(posedge clk) disable iff (rst)
		(m1 && (slot == slotT'(1) || slot == slotT'(2))) |-> rd)
		else begin
			violations++;
			$error("m1 without rd in slot 1 or 2");
		end

	ackOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(irqAck))
		else begin
			violations++;
			$error("irqAck has more than one bit set");
		end

	addrStable: assert property (@(posedge clk) disable iff (rst)
		(slot != slotT'(0)) |-> $stable(addr))   // Only a new machine cycle moves addr
		else begin
			violations++;
			$error("addr changed inside a machine cycle");
		end

endmodule

bind sm83Core sm83Core_checker u_chk (
	.clk(clk), .rst(rst), .addr(addr), .rd(rd), .wr(wr), .m1(m1),
	.irqAck(irqAck), .slot(u_seq.slot)
);

//--- core/sm83Core.sv
`timescale 1ns/1ps
`include "sm83_consts.svh"

// Reduced SM83 core top, four clock slots per machine cycle

module sm83Core (
	input  logic                       clk,
	input  logic                       rst,
	output logic [15:0]                addr,      // Stable for a whole machine cycle
	input  logic [7:0]                 dataIn,
	output logic [7:0]                 dataOut,
	output logic                       rd,
	output logic                       wr,
	output logic                       m1,        // Opcode fetch cycle
	input  logic [`SM83_IRQ_LINES-1:0] irqTrig,   // Rising edge requests
	output logic [`SM83_IRQ_LINES-1:0] irqAck     // One clock, one-hot
);

	coreBus cb ();                   // Sequencer, registers and ALU

	logic [15:0] pc;
	logic [15:0] sp;
	logic [15:0] hl;
	logic        pcInc;
	logic        pcLoad;
	logic [15:0] pcLoadVal;
	logic        spInc;
	logic        spDec;
	logic        spLoad;
	logic        imeSet;
	logic        imeClr;
	logic        ieWrite;
	logic [7:0]  ieData;
	logic        irqPending;
	logic        wakeReq;
	logic [2:0]  irqVec;
	logic        irqTake;

	sequencer u_seq (
		.clk(clk), .rst(rst), .bus(cb.seq),
		.addr(addr), .dataIn(dataIn), .dataOut(dataOut),
		.rd(rd), .wr(wr), .m1(m1),
		.pc(pc), .sp(sp), .hl(hl),
		.pcInc(pcInc), .pcLoad(pcLoad), .pcLoadVal(pcLoadVal),
		.spInc(spInc), .spDec(spDec), .spLoad(spLoad),
		.imeSet(imeSet), .imeClr(imeClr), .ieWrite(ieWrite), .ieData(ieData),
		.irqPending(irqPending), .wakeReq(wakeReq), .irqVec(irqVec), .irqTake(irqTake)
	);

	regFile u_regs (
		.clk(clk), .rst(rst), .bus(cb.regs),
		.pcInc(pcInc), .pcLoad(pcLoad), .pcLoadVal(pcLoadVal),
		.spInc(spInc), .spDec(spDec), .spLoad(spLoad),
		.dl16({dataIn, cb.dl}),      // High byte still on the pins at load
		.pc(pc), .sp(sp), .hl(hl)
	);

	alu u_alu (.clk(clk), .rst(rst), .bus(cb.alu));

	irqLogic u_irq (
		.clk(clk), .rst(rst), .irqTrig(irqTrig), .irqAck(irqAck),
		.imeSet(imeSet), .imeClr(imeClr), .ieWrite(ieWrite), .ieData(ieData),
		.irqTake(irqTake), .irqPending(irqPending), .wakeReq(wakeReq), .irqVec(irqVec)
	);

endmodule

//--- core/sequencer.sv
`timescale 1ns/1ps
`include "sm83_consts.svh"

module sequencer (
	input  logic        clk,
	input  logic        rst,
	coreBus.seq         bus,
	output logic [15:0] addr,
	input  logic [7:0]  dataIn,
	output logic [7:0]  dataOut,
	output logic        rd,
	output logic        wr,
	output logic        m1,
	input  logic [15:0] pc,
	input  logic [15:0] sp,
	input  logic [15:0] hl,
	output logic        pcInc,
	output logic        pcLoad,
	output logic [15:0] pcLoadVal,
	output logic        spInc,
	output logic        spDec,
	output logic        spLoad,
	output logic        imeSet,
	output logic        imeClr,
	output logic        ieWrite,
	output logic [7:0]  ieData,
	input  logic        irqPending,
	input  logic        wakeReq,
	input  logic [2:0]  irqVec,
	output logic        irqTake
);
	import sm83Pkg::*;
	import busPkg::*;

	typedef enum logic [2:0] {
		S_RESET, S_FETCH, S_READ1, S_READ2, S_WRITE, S_IDLE, S_HALT, S_DISP
	} stateT;

	stateT    state, nextState;
	slotT     slot;
	busCycleT cyc;
	logic [2:0] mc, nextMc;             // Dispatch machine cycle 0..4
	logic [7:0] opcode, dlQ, opLo;
	logic [2:0] vecQ;                   // Vector held across dispatch
	logic lastSlot, sampleSlot, instrDone, isIeAddr;
	logic isLdR, isLdSp, isJp, isStA, isHalt, isEi, isDi, isAlu;

	assign lastSlot   = slot == slotT'(`SM83_SLOTS - 1);
	assign sampleSlot = slot == slotT'(2);   // dataIn valid at end of slot 2

	// Decoder
	assign isLdR  = opcode[7:6] == 2'b00 && opcode[2:0] == 3'b110
		&& regIdxT'(opcode[5:3]) != HLMEM;
	assign isAlu  = opcode[7:6] == 2'b10 && regIdxT'(opcode[2:0]) != HLMEM;
	assign isLdSp = opcode == 8'h31;
	assign isJp   = opcode == 8'hC3;
	assign isStA  = opcode == 8'h77;    // LD (HL),A
	assign isHalt = opcode == 8'h76;
	assign isEi   = opcode == 8'hFB;
	assign isDi   = opcode == 8'hF3;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_RESET;
			slot  <= '0;
			mc    <= '0;
		end else if (state == S_RESET) begin
			state <= S_FETCH;             // First fetch right after reset
			slot  <= '0;
		end else begin
			slot <= lastSlot ? slotT'(0) : slot + slotT'(1);
			if (lastSlot) begin
				state <= nextState;
				mc    <= nextMc;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sampleSlot && state == S_FETCH)
			opcode <= dataIn;
		if (sampleSlot && (state == S_READ1 || state == S_READ2)) begin
			dlQ  <= dataIn;
			opLo <= dlQ;                  // Low byte of a 16-bit operand
		end
		if (irqTake)
			vecQ <= irqVec;
	end

	always_comb begin
		instrDone = 1'b0;
		nextState = state;
		nextMc    = '0;
		case (state)
			S_FETCH: begin
				if (isLdR || isLdSp || isJp) nextState = S_READ1;
				else if (isStA) nextState = S_WRITE;
				else if (isHalt) nextState = S_HALT;
				else instrDone = 1'b1;
			end
			S_READ1: if (isLdSp || isJp) nextState = S_READ2; else instrDone = 1'b1;
			S_READ2: if (isJp) nextState = S_IDLE; else instrDone = 1'b1;
			S_WRITE, S_IDLE: instrDone = 1'b1;
			S_HALT: instrDone = wakeReq;    // Leave halt on any enabled flag
			S_DISP: begin
				if (mc == 3'd4) nextState = S_FETCH;
				else nextMc = mc + 3'd1;
			end
			default: nextState = S_FETCH;
		endcase
		// Instruction boundary, DI wins over a pending request
		if (instrDone)
			nextState = (irqPending && !(state == S_FETCH && isDi)) ? S_DISP : S_FETCH;
	end

	always_comb begin
		case (state)
			S_FETCH, S_READ1, S_READ2: cyc = READ;
			S_WRITE: cyc = WRITE;
			S_DISP: cyc = (mc == 3'd2 || mc == 3'd3) ? WRITE : IDLE;
			default: cyc = IDLE;
		endcase
		case (state)
			S_WRITE: addr = hl;
			S_DISP: addr = sp;              // Walks down as the PC is pushed
			default: addr = pc;
		endcase
	end

	assign isIeAddr = addr == `SM83_IE_ADDR;
	assign m1       = state == S_FETCH;
	assign rd       = cyc == READ && (slot == slotT'(1) || slot == slotT'(2));
	assign wr       = cyc == WRITE && slot == slotT'(2) && !isIeAddr;
	assign ieWrite  = cyc == WRITE && slot == slotT'(2) && isIeAddr;
	assign dataOut  = (state != S_DISP) ? bus.regA : (mc == 3'd2) ? pc[15:8] : pc[7:0];
	assign ieData   = dataOut;

	// PC and SP steps, all at a machine cycle edge except the SP load
	assign pcInc     = lastSlot && (state == S_FETCH || state == S_READ1 || state == S_READ2);
	assign pcLoad    = lastSlot && (state == S_IDLE || (state == S_DISP && mc == 3'd4));
	assign pcLoadVal = (state == S_DISP) ? `SM83_IRQ_BASE + {10'd0, vecQ, 3'b000}
		: {dlQ, opLo};
	assign spLoad    = sampleSlot && state == S_READ2 && isLdSp;
	assign spDec     = lastSlot && state == S_DISP && (mc == 3'd1 || mc == 3'd2);
	assign spInc     = 1'b0;         // No pop in this opcode subset

	assign imeSet  = lastSlot && state == S_FETCH && isEi;
	assign imeClr  = lastSlot && state == S_FETCH && isDi;
	assign irqTake = state == S_DISP && mc == 3'd0 && slot == slotT'(0);

	// Register file and ALU controls
	assign bus.dl      = dlQ;
	assign bus.regSel  = (state == S_READ1) ? regIdxT'(opcode[5:3]) : regIdxT'(opcode[2:0]);
	assign bus.regWe   = lastSlot && state == S_READ1 && isLdR;
	assign bus.dlToReg = state == S_READ1;
	assign bus.aluOp   = aluOpT'(opcode[5:3]);
	assign bus.aluGo   = lastSlot && state == S_FETCH && isAlu;

endmodule

//--- core/irqLogic.sv
`timescale 1ns/1ps
`include "sm83_consts.svh"

// Interrupt flags, enables, master enable and priority

module irqLogic (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [`SM83_IRQ_LINES-1:0] irqTrig,
	output logic [`SM83_IRQ_LINES-1:0] irqAck,
	input  logic                       imeSet,
	input  logic                       imeClr,
	input  logic                       ieWrite,
	input  logic [7:0]                 ieData,
	input  logic                       irqTake,
	output logic                       irqPending,
	output logic                       wakeReq,
	output logic [2:0]                 irqVec
);

	logic [`SM83_IRQ_LINES-1:0] trigQ;      // Previous trigger level
	logic [`SM83_IRQ_LINES-1:0] ifQ;        // IF
	logic [`SM83_IRQ_LINES-1:0] ieQ;        // IE at 0xFFFF
	logic [`SM83_IRQ_LINES-1:0] match;
	logic [`SM83_IRQ_LINES-1:0] rise;
	logic [`SM83_IRQ_LINES-1:0] ackMask;
	logic                       ime;

	assign rise  = irqTrig & ~trigQ;
	assign match = ieQ & ifQ;

	// Lowest line number wins
	always_comb begin
		irqVec  = 3'd0;
		ackMask = '0;
		for (int i = `SM83_IRQ_LINES - 1; i >= 0; i--)
			if (match[i])
				irqVec = 3'(i);
		if (|match)
			ackMask[irqVec] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			trigQ <= '0;
			ifQ   <= '0;
			ieQ   <= '0;
			ime   <= 1'b0;
		end else begin
			trigQ <= irqTrig;
			ifQ   <= (ifQ & ~(irqTake ? ackMask : '0)) | rise;   // New edge beats the clear
			if (ieWrite)
				ieQ <= ieData[`SM83_IRQ_LINES-1:0];
			if (irqTake || imeClr)
				ime <= 1'b0;                 // Dispatch masks further requests
			else if (imeSet)
				ime <= 1'b1;
		end
	end

	assign irqAck     = irqTake ? ackMask : '0;
	assign irqPending = ime && |match;
	assign wakeReq    = |match;             // Halt exit ignores IME

endmodule

//--- core/regFile.sv
`timescale 1ns/1ps
`include "sm83_consts.svh"

// General registers plus PC and SP

module regFile (
	input  logic        clk,
	input  logic        rst,
	coreBus.regs        bus,
	input  logic        pcInc,
	input  logic        pcLoad,
	input  logic [15:0] pcLoadVal,
	input  logic        spInc,
	input  logic        spDec,
	input  logic        spLoad,
	input  logic [15:0] dl16,       // 16-bit immediate for SP
	output logic [15:0] pc,
	output logic [15:0] sp,
	output logic [15:0] hl
);
	import sm83Pkg::*;

	logic [7:0]  regs [8];          // Indexed by the opcode register field
	logic [15:0] pcQ;
	logic [15:0] spQ;
	logic [15:0] spStep;            // Shared inc/dec adder input

	always_ff @(posedge clk) begin
		if (bus.regWe)
			regs[bus.regSel] <= bus.dlToReg ? bus.dl : bus.aluRes;
		else if (bus.aluGo && bus.aluOp != CP)
			regs[A] <= bus.aluRes;       // CP leaves A alone
	end

	assign spStep = spDec ? 16'hFFFF : 16'h0001;

	always_ff @(posedge clk) begin
		if (rst) begin
			pcQ <= `SM83_RESET_PC;
			spQ <= `SM83_RESET_SP;
		end else begin
			if (pcLoad)
				pcQ <= pcLoadVal;          // Jump or interrupt vector
			else if (pcInc)
				pcQ <= pcQ + 16'd1;
			if (spLoad)
				spQ <= dl16;
			else if (spInc || spDec)
				spQ <= spQ + spStep;
		end
	end

	assign pc         = pcQ;
	assign sp         = spQ;
	assign hl         = {regs[H], regs[L]};
	assign bus.regA   = regs[A];
	assign bus.regOut = regs[bus.regSel];

endmodule

//--- core/alu.sv
`timescale 1ns/1ps

// 8-bit ALU with its own flag register

module alu (
	input logic clk,
	input logic rst,
	coreBus.alu bus
);
	import sm83Pkg::*;

	flagsT      flags;          // Committed flags
	flagsT      flagsNext;
	logic [7:0] opA;
	logic [7:0] opB;
	logic [7:0] res;
	logic [8:0] full;           // Bit 8 is carry or borrow
	logic [4:0] half;           // Bit 4 is half carry or borrow
	logic       cin;
	logic       isSub;

	always_comb begin
		opA   = bus.regA;
		opB   = bus.regOut;
		isSub = bus.aluOp inside {SUB, SBC, CP};
		cin   = (bus.aluOp inside {ADC, SBC}) && flags.c;   // Stored carry in
		if (isSub) begin
			half = {1'b0, opA[3:0]} - {1'b0, opB[3:0]} - {4'd0, cin};
			full = {1'b0, opA} - {1'b0, opB} - {8'd0, cin};
		end else begin
			half = {1'b0, opA[3:0]} + {1'b0, opB[3:0]} + {4'd0, cin};
			full = {1'b0, opA} + {1'b0, opB} + {8'd0, cin};
		end
		res         = full[7:0];
		flagsNext.n = isSub;
		flagsNext.h = half[4];
		flagsNext.c = full[8];
		case (bus.aluOp)
			AND: begin
				res         = opA & opB;
				flagsNext.h = 1'b1;      // AND always sets H
				flagsNext.c = 1'b0;
			end
			XOR: begin
				res         = opA ^ opB;
				flagsNext.h = 1'b0;
				flagsNext.c = 1'b0;
			end
			OR: begin
				res         = opA | opB;
				flagsNext.h = 1'b0;
				flagsNext.c = 1'b0;
			end
			default: ;
		endcase
		flagsNext.z = res == 8'h00;     // CP flags its difference
	end

	assign bus.aluRes = res;

	always_ff @(posedge clk) begin
		if (rst)
			flags <= '0;
		else if (bus.aluGo)
			flags <= flagsNext;          // Commit with the A write
	end

endmodule

//--- common/coreBus.sv
`timescale 1ns/1ps

// Internal data bus and register/ALU controls

interface coreBus;

	logic [7:0]      dl;        // Operand byte latched from dataIn
	sm83Pkg::regIdxT regSel;    // Register picked by the opcode
	logic            regWe;     // Write the selected register
	logic            dlToReg;   // Write source is dl, else ALU result
	sm83Pkg::aluOpT  aluOp;     // Current ALU operation
	logic            aluGo;     // One-clock ALU commit strobe
	logic [7:0]      regA;      // Accumulator
	logic [7:0]      regOut;    // Selected register value
	logic [7:0]      aluRes;    // ALU result

	modport seq (
		output dl, regSel, regWe, dlToReg, aluOp, aluGo,
		input  regA, regOut, aluRes
	);

	modport regs (
		input  dl, regSel, regWe, dlToReg, aluOp, aluGo, aluRes,
		output regA, regOut
	);

	modport alu (
		input  regA, regOut, aluOp, aluGo,
		output aluRes
	);

endinterface

//--- common/busPkg.sv
// Bus-side types of the SM83 core

package busPkg;

	// Kind of external access in one machine cycle
	typedef enum logic [1:0] {
		IDLE  = 2'd0,  // No strobe
		READ  = 2'd1,  // rd in slots 1 and 2
		WRITE = 2'd2   // wr in slot 2
	} busCycleT;

	typedef logic [1:0] slotT;    // Slot 0 to 3 inside a machine cycle

endpackage

//--- common/sm83Pkg.sv
// Instruction-side types of the SM83 core

package sm83Pkg;

	// ALU operation, straight from opcode bits 5:3 of the 10ooorrr group
	typedef enum logic [2:0] {
		ADD = 3'd0,    // A + r
		ADC = 3'd1,    // A + r + carry
		SUB = 3'd2,    // A - r
		SBC = 3'd3,    // A - r - carry
		AND = 3'd4,    // A & r
		XOR = 3'd5,    // A ^ r
		OR  = 3'd6,    // A | r
		CP  = 3'd7     // Compare, flags only
	} aluOpT;

	// Register field as coded in the opcode
	typedef enum logic [2:0] {
		B     = 3'd0,
		C     = 3'd1,
		D     = 3'd2,
		E     = 3'd3,
		H     = 3'd4,
		L     = 3'd5,
		HLMEM = 3'd6,  // Memory at HL, not a register
		A     = 3'd7   // Accumulator
	} regIdxT;

	// Flag register, same bit order as the upper nibble of F
	typedef struct packed {
		logic z;       // Result zero
		logic n;       // Last op was a subtract
		logic h;       // Carry or borrow out of bit 3
		logic c;       // Carry or borrow out of bit 7
	} flagsT;

endpackage

//--- common/sm83_consts.svh
`ifndef SM83_CONSTS_SVH
`define SM83_CONSTS_SVH

// Core-wide constants for the reduced SM83 core

`define SM83_RESET_PC   16'h0000    // First opcode fetch address
`define SM83_RESET_SP   16'hFFFE    // Stack pointer after reset

`define SM83_IE_ADDR    16'hFFFF    // Internal IE register, never reaches the bus
`define SM83_IRQ_BASE   16'h0040    // Vector of IRQ line 0
`define SM83_IRQ_LINES  5           // Number of interrupt request lines

// Every machine cycle is split into this many clock slots
`define SM83_SLOTS      4

`endif
